// File: lookahead_macros.svh
`ifndef LOOKAHEAD_MACROS_SVH
`define LOOKAHEAD_MACROS_SVH

`define MESH_NX       4         // routers along x
`define MESH_NY       4         // routers along y
`define COORD_XW      2         // bits of an x address
`define COORD_YW      2         // bits of a y address

`define ROUTER_PORTS  5
`define PORT_LOCAL    0
`define PORT_EAST     1
`define PORT_NORTH    2         // toward smaller y
`define PORT_WEST     3
`define PORT_SOUTH    4         // toward larger y

`endif

// File: lookahead_pkg.sv
`include "lookahead_macros.svh"

package lookahead_pkg;

    // router address, one field per mesh axis
    typedef logic [`COORD_XW-1:0] coord_x_t;
    typedef logic [`COORD_YW-1:0] coord_y_t;

    // one bit per router port, indexed local/east/north/west/south
    typedef logic [`ROUTER_PORTS-1:0] port_onehot_t;

    // one-hot with a reference port squeezed out, so bit k is the k-th
    // remaining port in ascending order
    typedef logic [`ROUTER_PORTS-2:0] port_compact_t;

    typedef logic [$clog2(`ROUTER_PORTS)-1:0]   port_idx_t;    // binary index of a full port
    typedef logic [$clog2(`ROUTER_PORTS-1)-1:0] port_cidx_t;   // binary index in compact form

endpackage

// File: next_hop_predictor.sv
`timescale 1ns/1ps
`include "lookahead_macros.svh"

module next_hop_predictor #(
    parameter int SW_LOC = `PORT_LOCAL      // input port served by this routing unit
) (
    input  lookahead_pkg::port_compact_t destport,
    input  lookahead_pkg::coord_x_t      current_x,
    input  lookahead_pkg::coord_y_t      current_y,
    output lookahead_pkg::coord_x_t      next_x,
    output lookahead_pkg::coord_y_t      next_y,
    output lookahead_pkg::port_onehot_t  entry_port
);
    import lookahead_pkg::*;

    localparam coord_x_t LAST_X = coord_x_t'(`MESH_NX - 1);
    localparam coord_y_t LAST_Y = coord_y_t'(`MESH_NY - 1);

    port_onehot_t destport_full;    // out port at this router, all five ports

    // a packet never leaves by the port it came in on, so that bit is zero
    for (genvar i = 0; i < `ROUTER_PORTS; i++) begin : g_expand
        if (i < SW_LOC) begin : g_below
            assign destport_full[i] = destport[i];
        end else if (i == SW_LOC) begin : g_own
            assign destport_full[i] = 1'b0;
        end else begin : g_above
            assign destport_full[i] = destport[i-1];       // shifted up past SW_LOC
        end
    end

    // neighbour address in the chosen direction, wraps at the mesh edges
    always_comb begin
        next_x = current_x;                                 // local or idle keeps address
        next_y = current_y;
        if (destport_full[`PORT_EAST]) begin
            next_x = (current_x == LAST_X) ? '0 : current_x + 1'b1;
        end else if (destport_full[`PORT_NORTH]) begin
            next_y = (current_y == '0) ? LAST_Y : current_y - 1'b1;
        end else if (destport_full[`PORT_WEST]) begin
            next_x = (current_x == '0) ? LAST_X : current_x - 1'b1;
        end else if (destport_full[`PORT_SOUTH]) begin
            next_y = (current_y == LAST_Y) ? '0 : current_y + 1'b1;
        end
    end

    // packet arrives through the opposite side of the next router
    assign entry_port[`PORT_LOCAL] = destport_full[`PORT_LOCAL];
    assign entry_port[`PORT_EAST]  = destport_full[`PORT_WEST];
    assign entry_port[`PORT_WEST]  = destport_full[`PORT_EAST];
    assign entry_port[`PORT_NORTH] = destport_full[`PORT_SOUTH];
    assign entry_port[`PORT_SOUTH] = destport_full[`PORT_NORTH];

endmodule

// File: xy_route.sv
`timescale 1ns/1ps
`include "lookahead_macros.svh"

module xy_route (
    input  lookahead_pkg::coord_x_t     current_x,     // router doing the routing
    input  lookahead_pkg::coord_y_t     current_y,
    input  lookahead_pkg::coord_x_t     dest_x,
    input  lookahead_pkg::coord_y_t     dest_y,
    output lookahead_pkg::port_onehot_t route_onehot
);
    import lookahead_pkg::*;

    port_idx_t route_idx;   // selected output port

    // dimension order: finish x before touching y
    always_comb begin
        if (dest_x > current_x) begin
            route_idx = port_idx_t'(`PORT_EAST);
        end else if (dest_x < current_x) begin
            route_idx = port_idx_t'(`PORT_WEST);
        end else if (dest_y > current_y) begin
            route_idx = port_idx_t'(`PORT_SOUTH);          // y grows southward
        end else if (dest_y < current_y) begin
            route_idx = port_idx_t'(`PORT_NORTH);
        end else begin
            route_idx = port_idx_t'(`PORT_LOCAL);          // arrived
        end
    end

    assign route_onehot = port_onehot_t'(1) << route_idx;   // exactly one bit high

endmodule

// File: lookahead_port_encoder.sv
`timescale 1ns/1ps
`include "lookahead_macros.svh"

module lookahead_port_encoder (
    input  lookahead_pkg::port_onehot_t  route_onehot,  // out port at the next router
    input  lookahead_pkg::port_onehot_t  entry_port,    // port it enters that router by
    output lookahead_pkg::port_compact_t lkdestport
);
    import lookahead_pkg::*;

    port_idx_t  route_idx;
    port_idx_t  entry_idx;
    port_idx_t  shifted_idx;
    port_cidx_t compact_idx;

    // or of the indices of all set bits, exact for a one-hot input
    function automatic port_idx_t onehot_to_idx(input port_onehot_t oh);
        port_idx_t idx;
        idx = '0;
        for (int i = 0; i < `ROUTER_PORTS; i++) begin
            if (oh[i]) begin
                idx = idx | port_idx_t'(i);
            end
        end
        return idx;
    endfunction

    assign route_idx = onehot_to_idx(route_onehot);
    assign entry_idx = onehot_to_idx(entry_port);      // all zero maps to local

    // ports above the entry port move down one slot
    assign shifted_idx = (entry_idx > route_idx) ? route_idx : route_idx - 1'b1;
    assign compact_idx = shifted_idx[$bits(port_cidx_t)-1:0];

    assign lkdestport = port_compact_t'(1) << compact_idx;

endmodule

// File: look_ahead_routing.sv
`timescale 1ns/1ps
`include "lookahead_macros.svh"

module look_ahead_routing #(
    parameter int SW_LOC = `PORT_LOCAL      // input port this unit sits on
) (
    input  logic                         clk,
    input  logic                         reset,
    input  lookahead_pkg::coord_x_t      current_x,    // this router's address
    input  lookahead_pkg::coord_y_t      current_y,
    input  lookahead_pkg::coord_x_t      dest_x,       // packet destination
    input  lookahead_pkg::coord_y_t      dest_y,
    input  lookahead_pkg::port_compact_t destport,     // out port here, compact
    output lookahead_pkg::port_compact_t lkdestport    // out port at next router
);
    import lookahead_pkg::*;

    coord_x_t      dest_x_q;
    coord_y_t      dest_y_q;
    port_compact_t destport_q;

    coord_x_t      next_x;
    coord_y_t      next_y;
    port_onehot_t  entry_port;
    port_onehot_t  route_onehot;

    // header stage, result is due when the packet reaches the switch
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dest_x_q   <= '0;
            dest_y_q   <= '0;
            destport_q <= '0;
        end else begin
            dest_x_q   <= dest_x;
            dest_y_q   <= dest_y;
            destport_q <= destport;
        end
    end

    next_hop_predictor #(
        .SW_LOC     (SW_LOC)
    ) next_hop_predictor_inst (
        .destport   (destport_q),
        .current_x  (current_x),
        .current_y  (current_y),
        .next_x     (next_x),
        .next_y     (next_y),
        .entry_port (entry_port)
    );

    // route as the next router would see it
    xy_route xy_route_inst (
        .current_x    (next_x),
        .current_y    (next_y),
        .dest_x       (dest_x_q),
        .dest_y       (dest_y_q),
        .route_onehot (route_onehot)
    );

    lookahead_port_encoder lookahead_port_encoder_inst (
        .route_onehot (route_onehot),
        .entry_port   (entry_port),
        .lkdestport   (lkdestport)
    );

endmodule

// File: tb_look_ahead_routing.sv
`timescale 1ns/1ps
`include "lookahead_macros.svh"

module tb_look_ahead_routing;
    import lookahead_pkg::*;

    localparam int SW_LOC           = `PORT_EAST;  // unit on the east input so east is squeezed out
    localparam int CLK_PERIOD       = 20;
    localparam int RESET_CYCLES     = 16;
    localparam int MID_RESET_CYCLES = 3;
    localparam int RESET_TEST       = 6;           // this test opens with a reset pulse
    localparam int FIELDS           = 7;           // hex words per trace line
    localparam int MAX_VECTORS      = 64;
    localparam int RELEASE_TIMEOUT  = 40;          // cycles
    localparam int RUN_TIMEOUT      = 500;         // cycles
    localparam logic [7:0] END_MARK = 8'hff;

    logic          clk;
    logic          reset;
    logic          por_reset;     // power-on part
    logic          run_reset;     // pulse issued in mid-run
    coord_x_t      current_x;
    coord_y_t      current_y;
    coord_x_t      dest_x;
    coord_y_t      dest_y;
    port_compact_t destport;
    port_compact_t lkdestport;

    logic [7:0] trace_mem [0:MAX_VECTORS*FIELDS-1];

    int pass_count;
    int fail_count;
    int test_errors;              // errors of the test now running
    int test_vectors;

    assign reset = por_reset | run_reset;

    look_ahead_routing #(
        .SW_LOC     (SW_LOC)
    ) look_ahead_routing_inst (
        .clk        (clk),
        .reset      (reset),
        .current_x  (current_x),
        .current_y  (current_y),
        .dest_x     (dest_x),
        .dest_y     (dest_y),
        .destport   (destport),
        .lkdestport (lkdestport)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        por_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        por_reset = 1'b0;
    end

    function automatic logic [7:0] field_of(input int idx, input int col);
        return trace_mem[idx*FIELDS + col];
    endfunction

    function automatic int test_of(input int idx);
        return int'(field_of(idx, 0));
    endfunction

    function automatic bit vector_valid(input int idx);
        bit valid;
        valid = 1'b0;
        if (idx < MAX_VECTORS) begin
            valid = (field_of(idx, 0) != END_MARK);
        end
        return valid;
    endfunction

    function automatic string test_name(input int test_no);
        string name;
        case (test_no)
            1:       name = "local delivery at the next hop";
            2:       name = "straight continuation";
            3:       name = "turn from x to y";
            4:       name = "moves toward a mesh edge";
            5:       name = "back-to-back destinations";
            6:       name = "reset in mid-run";
            default: name = "unnamed";
        endcase
        return name;
    endfunction

    // compact bit k is port k below SW_LOC and port k+1 from there on
    function automatic int expand_port(input logic [3:0] compact);
        int port;
        port = -1;                                      // nothing set
        for (int k = 0; k < 4; k++) begin
            if (compact[k]) begin
                port = (k < SW_LOC) ? k : k + 1;
            end
        end
        return port;
    endfunction

    function automatic int opposite_port(input int port);
        int opp;
        case (port)
            `PORT_EAST:  opp = `PORT_WEST;
            `PORT_WEST:  opp = `PORT_EAST;
            `PORT_NORTH: opp = `PORT_SOUTH;
            `PORT_SOUTH: opp = `PORT_NORTH;
            default:     opp = `PORT_LOCAL;
        endcase
        return opp;
    endfunction

    function automatic int xy_port(input int cx, input int cy, input int dx, input int dy);
        int port;
        if (dx > cx) begin
            port = `PORT_EAST;
        end else if (dx < cx) begin
            port = `PORT_WEST;
        end else if (dy > cy) begin
            port = `PORT_SOUTH;                         // south is larger y
        end else if (dy < cy) begin
            port = `PORT_NORTH;
        end else begin
            port = `PORT_LOCAL;
        end
        return port;
    endfunction

    function automatic logic [3:0] expected_lookahead(input int cx, input int cy,
                                                      input int dx, input int dy,
                                                      input logic [3:0] port_here);
        int out_port;
        int nx;
        int ny;
        int entry;
        int route;
        int slot;
        logic [3:0] result;
        out_port = expand_port(port_here);
        nx = cx;
        ny = cy;
        case (out_port)
            `PORT_EAST:  nx = (cx + 1) % `MESH_NX;
            `PORT_WEST:  nx = (cx + `MESH_NX - 1) % `MESH_NX;
            `PORT_NORTH: ny = (cy + `MESH_NY - 1) % `MESH_NY;
            `PORT_SOUTH: ny = (cy + 1) % `MESH_NY;
            default:     nx = cx;                       // address unchanged
        endcase
        entry = opposite_port(out_port);
        route = xy_port(nx, ny, dx, dy);
        slot = (entry > route) ? route : route - 1;
        result = '0;
        if (slot >= 0) begin
            result[slot] = 1'b1;
        end
        return result;
    endfunction

    task automatic drive_vector(input int idx);
        current_x = coord_x_t'(field_of(idx, 1));
        current_y = coord_y_t'(field_of(idx, 2));
        dest_x    = coord_x_t'(field_of(idx, 3));
        dest_y    = coord_y_t'(field_of(idx, 4));
        destport  = port_compact_t'(field_of(idx, 5));
    endtask

    task automatic check_vector(input int idx);
        logic [3:0] expected;
        logic [7:0] listed;
        expected = expected_lookahead(int'(field_of(idx, 1)), int'(field_of(idx, 2)),
                                      int'(field_of(idx, 3)), int'(field_of(idx, 4)),
                                      port_compact_t'(field_of(idx, 5)));
        listed = field_of(idx, 6);
        test_vectors++;
        if (listed !== {4'h0, expected}) begin
            $display("trace error in test %0d vector %0d: file lists %h, rules give %h",
                     test_of(idx), idx, listed, expected);
            test_errors++;
        end
        if (lkdestport !== expected) begin
            $display("[ERROR] %0d ns test %0d vector %0d lkdestport expected %h got %h",
                     $time, test_of(idx), idx, expected, lkdestport);
            test_errors++;
        end
    endtask

    // zeroed registers must give the route from here toward the origin
    task automatic pulse_reset(input int idx);
        logic [3:0] expected;
        run_reset = 1'b1;
        drive_vector(idx);                              // captured after release
        repeat (MID_RESET_CYCLES) @(negedge clk);
        if (current_x != '0 || current_y != '0) begin
            expected = expected_lookahead(int'(current_x), int'(current_y), 0, 0, 4'b0000);
            if (lkdestport !== expected) begin
                $display("[ERROR] %0d ns test %0d during reset lkdestport expected %h got %h",
                         $time, test_of(idx), expected, lkdestport);
                test_errors++;
            end
        end
        run_reset = 1'b0;
    endtask

    task automatic report_test(input int test_no);
        if (test_errors == 0) begin
            $display("test %0d (%s) passed, %0d vectors", test_no, test_name(test_no),
                     test_vectors);
            pass_count++;
        end else begin
            $display("test %0d (%s) failed with %0d errors over %0d vectors", test_no,
                     test_name(test_no), test_errors, test_vectors);
            fail_count++;
        end
        test_errors = 0;
        test_vectors = 0;
    endtask

    task automatic wait_reset_release(output bit released);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (reset && cycles < RELEASE_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        released = !reset;
    endtask

    // each falling edge checks the previous vector before driving the next
    task automatic run_trace(output bit timed_out);
        int idx;
        int prev_idx;
        int cycles;
        bit pending;
        idx = 0;
        prev_idx = 0;
        cycles = 0;
        pending = 1'b0;
        timed_out = 1'b0;
        while (!timed_out && (pending || vector_valid(idx))) begin
            @(negedge clk);
            cycles++;
            if (pending) begin
                check_vector(prev_idx);
                pending = 1'b0;
                if (!vector_valid(idx) || test_of(idx) != test_of(prev_idx)) begin
                    report_test(test_of(prev_idx));
                end
            end
            if (vector_valid(idx)) begin
                if (test_of(idx) == RESET_TEST && (idx == 0 || test_of(idx - 1) != RESET_TEST)) begin
                    pulse_reset(idx);
                end else begin
                    drive_vector(idx);
                end
                prev_idx = idx;
                idx++;
                pending = 1'b1;
            end
            if (cycles >= RUN_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
    endtask

    initial begin
        bit released;
        bit timed_out;
        bit aborted;
        current_x = '0;
        current_y = '0;
        dest_x = '0;
        dest_y = '0;
        destport = '0;
        run_reset = 1'b0;
        pass_count = 0;
        fail_count = 0;
        test_errors = 0;
        test_vectors = 0;
        timed_out = 1'b0;
        aborted = 1'b0;
        for (int i = 0; i < MAX_VECTORS*FIELDS; i++) begin
            trace_mem[i] = END_MARK;
        end
        $readmemh("lookahead_trace.txt", trace_mem);
        if (!vector_valid(0)) begin
            $display("no vectors were found in lookahead_trace.txt");
            aborted = 1'b1;
        end
        wait_reset_release(released);
        if (!released) begin
            $display("timeout: reset was still asserted after %0d cycles", RELEASE_TIMEOUT);
            aborted = 1'b1;
        end else if (!aborted) begin
            run_trace(timed_out);
            if (timed_out) begin
                $display("timeout: the trace did not finish within %0d cycles", RUN_TIMEOUT);
                aborted = 1'b1;
            end
        end
        $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
        if (!aborted && fail_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: lookahead_trace.txt
// each line holds test number, current x and y, dest x and y, destport and expected lkdestport
// all fields are hex and both port fields use the compact one-hot form for a unit on the east input

// local delivery at the next hop
1 2 1 1 1 4 1
1 3 0 2 0 4 1
1 1 2 1 1 2 1
1 0 1 0 2 8 1
1 3 3 3 2 2 1
1 2 2 2 3 8 1

// straight continuation
2 3 1 0 1 4 4
2 2 3 0 3 4 4
2 1 3 1 0 2 4
2 2 2 2 0 2 4
2 0 0 0 3 8 8
2 3 1 3 3 8 8
2 3 0 0 0 4 4
2 0 3 0 1 2 4

// turn from x to y
3 2 0 1 2 4 8
3 3 3 2 1 4 2
3 1 1 0 3 4 8
3 3 2 2 0 4 2
3 2 1 1 0 4 2
3 3 0 2 3 4 8

// moves toward a mesh edge
4 1 0 0 3 4 8
4 1 2 0 2 4 1
4 0 1 0 0 2 1
4 3 2 3 3 8 1
4 1 3 0 0 4 2
4 2 1 2 0 2 1
4 0 2 0 3 8 1
4 1 1 0 0 4 2

// back-to-back destinations from the same routers
5 3 1 0 1 4 4
5 3 1 2 3 4 8
5 3 1 2 1 4 1
5 3 1 1 0 4 4
5 3 1 3 0 2 1
5 3 1 3 3 8 8
5 3 1 2 0 4 2
5 1 2 1 0 2 4
5 2 0 0 2 4 4
5 0 3 0 1 2 4
5 2 2 2 3 8 1
5 2 2 0 2 4 4
5 2 2 1 3 4 8
5 2 2 2 1 2 1

// first vectors after a reset pulse
6 2 2 0 0 4 4
6 3 0 3 2 8 8
6 1 1 1 2 8 1
6 2 3 1 1 4 2
6 3 3 0 3 4 4
6 0 2 0 0 2 4

// end of trace
ff 0 0 0 0 0 0

// File: tb.f
+incdir+.
lookahead_pkg.sv
next_hop_predictor.sv
xy_route.sv
lookahead_port_encoder.sv
look_ahead_routing.sv
tb_look_ahead_routing.sv

// File: Makefile
TOP := tb_look_ahead_routing

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder"
	@echo "make help   list these targets"

test:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f tb.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
